// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;
  localparam int mem_addr_width = 8;

  localparam logic [xlen-1:0] ecall_instruction = 32'h0000_0073;

  // funct3 encodings of the supported subset
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;
  localparam logic [2:0] f3_word = 3'b010;
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt = 7'b0100000;

  typedef enum logic [6:0] {
    OpReg    = 7'b0110011,
    OpImm    = 7'b0010011,
    OpLoad   = 7'b0000011,
    OpStore  = 7'b0100011,
    OpBranch = 7'b1100011,
    OpLui    = 7'b0110111,
    OpSystem = 7'b1110011
  } opcode_t;

  typedef enum logic [2:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOr,
    AluXor,
    AluSlt,
    AluPassB
  } alu_op_t;

  typedef enum logic [1:0] {
    FwdNone,
    FwdMem,
    FwdWb
  } forward_sel_t;

  typedef enum logic [1:0] {
    OwnerLoader,
    OwnerData,
    OwnerFetch
  } mem_owner_t;

endpackage

`default_nettype wire

// File: source/instruction_decoder.sv
`default_nettype none

module instruction_decoder
  import core_pkg::*;
(
  input  logic [xlen-1:0] id_instruction,
  output alu_op_t         alu_op,
  output logic            alu_b_imm,
  output logic            mem_read,
  output logic            mem_write,
  output logic            reg_write,
  output logic            wb_from_mem,
  output logic            is_branch,
  output logic            branch_ne,
  output logic            is_halt
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_op_t    funct_op;
  logic       funct_valid;

  assign opcode = opcode_t'(id_instruction[6:0]);
  assign funct3 = id_instruction[14:12];
  assign funct7 = id_instruction[31:25];

  // ALU operation shared by register and immediate forms
  always_comb begin
    funct_valid = 1'b1;
    case (funct3)
      f3_add_sub: funct_op = AluAdd;
      f3_slt:     funct_op = AluSlt;
      f3_xor:     funct_op = AluXor;
      f3_or:      funct_op = AluOr;
      f3_and:     funct_op = AluAnd;
      default: begin
        funct_op = AluAdd;
        funct_valid = 1'b0;
      end
    endcase
  end

  always_comb begin
    alu_op = AluAdd;
    alu_b_imm = 1'b0;
    mem_read = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    wb_from_mem = 1'b0;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    is_halt = 1'b0;
    case (opcode)
      OpReg: begin
        if (funct_valid && (funct7 == f7_base || (funct7 == f7_alt && funct3 == f3_add_sub))) begin
          reg_write = 1'b1;
          alu_op = (funct7 == f7_alt) ? AluSub : funct_op;
        end
      end
      OpImm: begin
        // No SLTI in this subset
        if (funct_valid && funct3 != f3_slt) begin
          reg_write = 1'b1;
          alu_b_imm = 1'b1;
          alu_op = funct_op;
        end
      end
      OpLoad: begin
        if (funct3 == f3_word) begin
          mem_read = 1'b1;
          reg_write = 1'b1;
          wb_from_mem = 1'b1;
          alu_b_imm = 1'b1;
        end
      end
      OpStore: begin
        if (funct3 == f3_word) begin
          mem_write = 1'b1;
          alu_b_imm = 1'b1;
        end
      end
      OpBranch: begin
        if (funct3 == f3_beq || funct3 == f3_bne) begin
          is_branch = 1'b1;
          branch_ne = (funct3 == f3_bne);
        end
      end
      OpLui: begin
        reg_write = 1'b1;
        alu_b_imm = 1'b1;
        alu_op = AluPassB;
      end
      OpSystem: is_halt = (id_instruction == ecall_instruction);
      default: alu_op = AluAdd;
    endcase
  end

endmodule

`default_nettype wire

// File: source/pipeline_datapath.sv
`default_nettype none

module pipeline_datapath
  import core_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      run,
  input  alu_op_t                   alu_op,
  input  logic                      alu_b_imm,
  input  logic                      mem_read,
  input  logic                      mem_write,
  input  logic                      reg_write,
  input  logic                      wb_from_mem,
  input  logic                      is_branch,
  input  logic                      branch_ne,
  input  logic                      is_halt,
  output logic [xlen-1:0]           id_instruction,
  input  forward_sel_t              forward_a,
  input  forward_sel_t              forward_b,
  input  logic                      stall_fetch,
  input  logic                      stall_decode,
  input  logic                      flush_decode,
  input  logic                      flush_execute,
  output logic [reg_addr_width-1:0] id_rs1,
  output logic [reg_addr_width-1:0] id_rs2,
  output logic [reg_addr_width-1:0] ex_rs1,
  output logic [reg_addr_width-1:0] ex_rs2,
  output logic [reg_addr_width-1:0] ex_rd,
  output logic                      ex_mem_read,
  output logic [reg_addr_width-1:0] mem_rd,
  output logic                      mem_reg_write,
  output logic [reg_addr_width-1:0] wb_rd,
  output logic                      wb_reg_write,
  output logic                      branch_taken,
  output logic [reg_addr_width-1:0] rf_rs1,
  output logic [reg_addr_width-1:0] rf_rs2,
  input  logic [xlen-1:0]           rf_data1,
  input  logic [xlen-1:0]           rf_data2,
  output logic                      rf_we,
  output logic [reg_addr_width-1:0] rf_waddr,
  output logic [xlen-1:0]           rf_wdata,
  output logic [mem_addr_width-1:0] fetch_addr,
  input  logic [xlen-1:0]           fetch_data,
  input  logic                      fetch_blocked,
  output logic                      data_read,
  output logic                      data_write,
  output logic [mem_addr_width-1:0] data_addr,
  output logic [xlen-1:0]           write_data,
  input  logic [xlen-1:0]           read_data,
  output logic                      retire_valid,
  output logic [reg_addr_width-1:0] retire_rd,
  output logic [xlen-1:0]           retire_data,
  output logic                      halted
);

  logic            step;
  logic            hold_fetch;
  logic            hold_decode;
  logic            bubble_execute;
  logic            fetch_done;
  logic            fetch_stop;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] id_pc;
  logic [xlen-1:0] id_imm;
  logic [xlen-1:0] ex_pc;
  logic [xlen-1:0] ex_a;
  logic [xlen-1:0] ex_b;
  logic [xlen-1:0] ex_imm;
  alu_op_t         ex_alu_op;
  logic            ex_alu_b_imm;
  logic            ex_mem_write;
  logic            ex_reg_write;
  logic            ex_use_load;
  logic            ex_is_branch;
  logic            ex_branch_ne;
  logic            ex_is_halt;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_b;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] branch_target;
  logic [xlen-1:0] mem_alu;
  logic [xlen-1:0] mem_store_data;
  logic            mem_mem_read;
  logic            mem_mem_write;
  logic            mem_use_load;
  logic            mem_is_halt;
  logic [xlen-1:0] wb_alu;
  logic [xlen-1:0] wb_load;
  logic [xlen-1:0] wb_value;
  logic            wb_use_load;
  logic            wb_is_halt;

  function automatic logic [xlen-1:0] forward_value(
    input forward_sel_t    sel,
    input logic [xlen-1:0] stage_value,
    input logic [xlen-1:0] mem_value,
    input logic [xlen-1:0] wb_result
  );
    case (sel)
      FwdMem:  return mem_value;
      FwdWb:   return wb_result;
      default: return stage_value;
    endcase
  endfunction

  assign step = run && !halted;
  assign hold_fetch = stall_fetch || fetch_blocked;
  assign hold_decode = stall_decode || fetch_blocked;
  assign bubble_execute = flush_execute || fetch_blocked;
  // Nothing is fetched once an ECALL has left decode
  assign fetch_stop = fetch_done || (is_halt && !stall_decode && !bubble_execute);

  assign id_rs1 = id_instruction[19:15];
  assign id_rs2 = id_instruction[24:20];
  assign rf_rs1 = id_instruction[19:15];
  assign rf_rs2 = id_instruction[24:20];

  always_comb begin
    case (opcode_t'(id_instruction[6:0]))
      OpStore:  id_imm = {{20{id_instruction[31]}}, id_instruction[31:25], id_instruction[11:7]};
      OpBranch: id_imm = {{19{id_instruction[31]}}, id_instruction[31], id_instruction[7],
                          id_instruction[30:25], id_instruction[11:8], 1'b0};
      OpLui:    id_imm = {id_instruction[31:12], 12'b0};
      default:  id_imm = {{20{id_instruction[31]}}, id_instruction[31:20]};
    endcase
  end

  always_comb begin
    op_a = forward_value(forward_a, ex_a, mem_alu, wb_value);
    op_b = forward_value(forward_b, ex_b, mem_alu, wb_value);
  end

  assign alu_b = ex_alu_b_imm ? ex_imm : op_b;

  always_comb begin
    case (ex_alu_op)
      AluSub:   alu_result = op_a - alu_b;
      AluAnd:   alu_result = op_a & alu_b;
      AluOr:    alu_result = op_a | alu_b;
      AluXor:   alu_result = op_a ^ alu_b;
      AluSlt:   alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      AluPassB: alu_result = alu_b;
      default:  alu_result = op_a + alu_b;
    endcase
  end

  // Branches resolve in EX
  assign branch_taken = ex_is_branch && ((op_a == op_b) != ex_branch_ne);
  assign branch_target = ex_pc + ex_imm;

  assign wb_value = wb_use_load ? wb_load : wb_alu;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
      id_instruction <= '0;
      fetch_done <= 1'b0;
      ex_rs1 <= '0;
      ex_rs2 <= '0;
      ex_rd <= '0;
      ex_alu_op <= AluAdd;
      ex_alu_b_imm <= 1'b0;
      ex_mem_read <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_use_load <= 1'b0;
      ex_is_branch <= 1'b0;
      ex_branch_ne <= 1'b0;
      ex_is_halt <= 1'b0;
      mem_rd <= '0;
      mem_mem_read <= 1'b0;
      mem_mem_write <= 1'b0;
      mem_reg_write <= 1'b0;
      mem_use_load <= 1'b0;
      mem_is_halt <= 1'b0;
      wb_rd <= '0;
      wb_reg_write <= 1'b0;
      wb_use_load <= 1'b0;
      wb_is_halt <= 1'b0;
      halted <= 1'b0;
    end else if (step) begin
      if (branch_taken) begin
        pc <= branch_target;
      end else if (!hold_fetch && !fetch_stop) begin
        pc <= pc + 32'd4;
      end
      if (flush_decode) begin
        id_instruction <= '0;
      end else if (!hold_decode) begin
        id_instruction <= fetch_stop ? '0 : fetch_data;
      end
      fetch_done <= fetch_stop;
      ex_rs1 <= id_rs1;
      ex_rs2 <= id_rs2;
      ex_rd <= id_instruction[11:7];
      ex_alu_op <= alu_op;
      ex_alu_b_imm <= alu_b_imm;
      ex_mem_read <= mem_read && !bubble_execute;
      ex_mem_write <= mem_write && !bubble_execute;
      ex_reg_write <= reg_write && !bubble_execute;
      ex_use_load <= wb_from_mem;
      ex_is_branch <= is_branch && !bubble_execute;
      ex_branch_ne <= branch_ne;
      ex_is_halt <= is_halt && !bubble_execute;
      mem_rd <= ex_rd;
      mem_mem_read <= ex_mem_read;
      mem_mem_write <= ex_mem_write;
      mem_reg_write <= ex_reg_write;
      mem_use_load <= ex_use_load;
      mem_is_halt <= ex_is_halt;
      wb_rd <= mem_rd;
      wb_reg_write <= mem_reg_write;
      wb_use_load <= mem_use_load;
      wb_is_halt <= mem_is_halt;
      halted <= wb_is_halt;
    end
  end

  always_ff @(posedge clock) begin
    if (step) begin
      if (!hold_decode) begin
        id_pc <= pc;
      end
      ex_pc <= id_pc;
      ex_a <= rf_data1;
      ex_b <= rf_data2;
      ex_imm <= id_imm;
      mem_alu <= alu_result;
      mem_store_data <= op_b;
      wb_alu <= mem_alu;
      wb_load <= read_data;
    end
  end

  assign fetch_addr = pc[mem_addr_width+1:2];
  assign data_read = mem_mem_read;
  assign data_write = mem_mem_write;
  assign data_addr = mem_alu[mem_addr_width+1:2];
  assign write_data = mem_store_data;

  assign rf_we = step && wb_reg_write && (wb_rd != '0);
  assign rf_waddr = wb_rd;
  assign rf_wdata = wb_value;

  assign retire_valid = rf_we;
  assign retire_rd = wb_rd;
  assign retire_data = wb_value;

endmodule

`default_nettype wire

// File: source/hazard_forwarding_unit.sv
`default_nettype none

module hazard_forwarding_unit
  import core_pkg::*;
(
  input  logic [reg_addr_width-1:0] id_rs1,
  input  logic [reg_addr_width-1:0] id_rs2,
  input  logic [reg_addr_width-1:0] ex_rs1,
  input  logic [reg_addr_width-1:0] ex_rs2,
  input  logic [reg_addr_width-1:0] ex_rd,
  input  logic                      ex_mem_read,
  input  logic [reg_addr_width-1:0] mem_rd,
  input  logic                      mem_reg_write,
  input  logic [reg_addr_width-1:0] wb_rd,
  input  logic                      wb_reg_write,
  input  logic                      branch_taken,
  output forward_sel_t              forward_a,
  output forward_sel_t              forward_b,
  output logic                      stall_fetch,
  output logic                      stall_decode,
  output logic                      flush_decode,
  output logic                      flush_execute
);

  logic load_use;

  // Younger producer in MEM wins over WB
  function automatic forward_sel_t select_source(input logic [reg_addr_width-1:0] rs);
    if (mem_reg_write && mem_rd != '0 && mem_rd == rs) begin
      return FwdMem;
    end
    if (wb_reg_write && wb_rd != '0 && wb_rd == rs) begin
      return FwdWb;
    end
    return FwdNone;
  endfunction

  always_comb begin
    forward_a = select_source(ex_rs1);
    forward_b = select_source(ex_rs2);
  end

  assign load_use = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

  assign stall_fetch = load_use;
  assign stall_decode = load_use;
  assign flush_decode = branch_taken;
  assign flush_execute = load_use || branch_taken;

endmodule

`default_nettype wire

// File: source/register_file.sv
`default_nettype none

module register_file
  import core_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic [reg_addr_width-1:0] rs1,
  input  logic [reg_addr_width-1:0] rs2,
  output logic [xlen-1:0]           data1,
  output logic [xlen-1:0]           data2,
  input  logic                      we,
  input  logic [reg_addr_width-1:0] waddr,
  input  logic [xlen-1:0]           wdata
);

  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 reads zero, a same-cycle write is passed through
  assign data1 = (rs1 == '0) ? '0 : (we && waddr == rs1) ? wdata : regs[rs1];
  assign data2 = (rs2 == '0) ? '0 : (we && waddr == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

// File: source/memory_arbiter.sv
`default_nettype none

module memory_arbiter
  import core_pkg::*;
(
  input  logic                      run,
  input  logic                      load_strobe,
  input  logic [mem_addr_width-1:0] load_addr,
  input  logic [xlen-1:0]           load_data,
  input  logic [mem_addr_width-1:0] fetch_addr,
  output logic [xlen-1:0]           fetch_data,
  output logic                      fetch_blocked,
  input  logic                      data_read,
  input  logic                      data_write,
  input  logic [mem_addr_width-1:0] data_addr,
  input  logic [xlen-1:0]           write_data,
  output logic [xlen-1:0]           read_data,
  output logic [mem_addr_width-1:0] mem_addr,
  output logic [xlen-1:0]           mem_wdata,
  output logic                      mem_we,
  input  logic [xlen-1:0]           mem_rdata,
  output mem_owner_t                owner
);

  // Loader only while stopped, data only while running
  always_comb begin
    if (load_strobe && !run) begin
      owner = OwnerLoader;
    end else if (run && (data_read || data_write)) begin
      owner = OwnerData;
    end else begin
      owner = OwnerFetch;
    end
  end

  always_comb begin
    case (owner)
      OwnerLoader: begin
        mem_addr = load_addr;
        mem_wdata = load_data;
        mem_we = 1'b1;
      end
      OwnerData: begin
        mem_addr = data_addr;
        mem_wdata = write_data;
        mem_we = data_write;
      end
      default: begin
        mem_addr = fetch_addr;
        mem_wdata = write_data;
        mem_we = 1'b0;
      end
    endcase
  end

  assign fetch_blocked = (owner != OwnerFetch);
  assign fetch_data = mem_rdata;
  assign read_data = mem_rdata;

endmodule

`default_nettype wire

// File: source/unified_memory.sv
`default_nettype none

module unified_memory
  import core_pkg::*;
(
  input  logic                      clock,
  input  logic [mem_addr_width-1:0] addr,
  input  logic [xlen-1:0]           wdata,
  input  logic                      we,
  output logic [xlen-1:0]           rdata
);

  logic [xlen-1:0] mem [0:(2**mem_addr_width)-1];

  always_ff @(posedge clock) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // Asynchronous read port
  assign rdata = mem[addr];

endmodule

`default_nettype wire

// File: source/core_top.sv
`default_nettype none

module core_top
  import core_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      run,
  input  logic                      load_strobe,
  input  logic [mem_addr_width-1:0] load_addr,
  input  logic [xlen-1:0]           load_data,
  output logic                      retire_valid,
  output logic [reg_addr_width-1:0] retire_rd,
  output logic [xlen-1:0]           retire_data,
  output logic                      halted
);

  // Decode controls
  logic [xlen-1:0]           id_instruction;
  alu_op_t                   alu_op;
  logic                      alu_b_imm;
  logic                      mem_read;
  logic                      mem_write;
  logic                      reg_write;
  logic                      wb_from_mem;
  logic                      is_branch;
  logic                      branch_ne;
  logic                      is_halt;

  // Hazard and forwarding
  forward_sel_t              forward_a;
  forward_sel_t              forward_b;
  logic                      stall_fetch;
  logic                      stall_decode;
  logic                      flush_decode;
  logic                      flush_execute;
  logic [reg_addr_width-1:0] id_rs1;
  logic [reg_addr_width-1:0] id_rs2;
  logic [reg_addr_width-1:0] ex_rs1;
  logic [reg_addr_width-1:0] ex_rs2;
  logic [reg_addr_width-1:0] ex_rd;
  logic                      ex_mem_read;
  logic [reg_addr_width-1:0] mem_rd;
  logic                      mem_reg_write;
  logic [reg_addr_width-1:0] wb_rd;
  logic                      wb_reg_write;
  logic                      branch_taken;

  // Register file
  logic [reg_addr_width-1:0] rf_rs1;
  logic [reg_addr_width-1:0] rf_rs2;
  logic [xlen-1:0]           rf_data1;
  logic [xlen-1:0]           rf_data2;
  logic                      rf_we;
  logic [reg_addr_width-1:0] rf_waddr;
  logic [xlen-1:0]           rf_wdata;

  // Shared memory port
  logic [mem_addr_width-1:0] fetch_addr;
  logic [xlen-1:0]           fetch_data;
  logic                      fetch_blocked;
  logic                      data_read;
  logic                      data_write;
  logic [mem_addr_width-1:0] data_addr;
  logic [xlen-1:0]           write_data;
  logic [xlen-1:0]           read_data;
  logic [mem_addr_width-1:0] mem_addr;
  logic [xlen-1:0]           mem_wdata;
  logic                      mem_we;
  logic [xlen-1:0]           mem_rdata;
  mem_owner_t                owner;

  pipeline_datapath pipeline_datapath_inst (.*);

  instruction_decoder instruction_decoder_inst (.*);

  hazard_forwarding_unit hazard_forwarding_unit_inst (.*);

  register_file register_file_inst (
    .clock(clock),
    .reset(reset),
    .rs1(rf_rs1),
    .rs2(rf_rs2),
    .data1(rf_data1),
    .data2(rf_data2),
    .we(rf_we),
    .waddr(rf_waddr),
    .wdata(rf_wdata)
  );

  memory_arbiter memory_arbiter_inst (.*);

  unified_memory unified_memory_inst (
    .clock(clock),
    .addr(mem_addr),
    .wdata(mem_wdata),
    .we(mem_we),
    .rdata(mem_rdata)
  );

endmodule

`default_nettype wire

// File: verification/core_top_props.sv
`default_nettype none

module core_top_props
  import core_pkg::*;
(
  input logic                      clock,
  input logic                      reset,
  input logic                      run,
  input logic                      retire_valid,
  input logic [reg_addr_width-1:0] retire_rd,
  input logic                      halted,
  input logic                      fetch_blocked,
  input mem_owner_t                owner
);

  retire_rd_nonzero: assert property (@(posedge clock) disable iff (reset)
    retire_valid |-> retire_rd != '0)
    else $error("retire_valid with retire_rd zero");

  // Halt only clears on reset
  halted_sticky: assert property (@(posedge clock) disable iff (reset)
    halted |=> halted)
    else $error("halted dropped without reset");

  blocked_by_data: assert property (@(posedge clock) disable iff (reset)
    (run && fetch_blocked) |-> owner == OwnerData)
    else $error("fetch blocked while running by an owner other than data");

endmodule

bind core_top core_top_props core_top_props_inst (
  .clock(clock),
  .reset(reset),
  .run(run),
  .retire_valid(retire_valid),
  .retire_rd(retire_rd),
  .halted(halted),
  .fetch_blocked(fetch_blocked),
  .owner(owner)
);

`default_nettype wire

// File: verification/core_top_tb.sv
`default_nettype none

module core_top_tb
  import core_pkg::*;
;

  logic                      clock;
  logic                      reset;
  logic                      run;
  logic                      load_strobe;
  logic [mem_addr_width-1:0] load_addr;
  logic [xlen-1:0]           load_data;
  logic                      retire_valid;
  logic [reg_addr_width-1:0] retire_rd;
  logic [xlen-1:0]           retire_data;
  logic                      halted;

  logic [31:0] prog_addr [$];
  logic [31:0] prog_word [$];
  logic [31:0] exp_rd [$];
  logic [31:0] exp_data [$];
  int          exp_test [$];
  int          test_checks [1:6];
  int          test_errors [1:6];
  logic        test_done [1:6];
  int          checks;
  int          errors;

  core_top core_top_inst (.*);

  always #10 clock = ~clock;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected, input int test);
    checks++;
    test_checks[test]++;
    if (actual !== expected) begin
      errors++;
      test_errors[test]++;
      $display("FAILED time %0t %s actual %h expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic read_stim;
    int          fd;
    int          n;
    int          t;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen("verification/core_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("the stim file could not be opened");
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) == "P") begin
        if ($sscanf(line, "P %h %h", a, b) == 2) begin
          prog_addr.push_back(a);
          prog_word.push_back(b);
        end
      end else if (n > 0 && line.getc(0) == "E") begin
        if ($sscanf(line, "E %d %d %h", t, a, b) == 3) begin
          exp_test.push_back(t);
          exp_rd.push_back(a);
          exp_data.push_back(b);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic load_program;
    foreach (prog_addr[i]) begin
      @(negedge clock);
      load_strobe = 1'b1;
      load_addr = prog_addr[i][mem_addr_width-1:0];
      load_data = prog_word[i];
    end
    @(negedge clock);
    load_strobe = 1'b0;
  endtask

  task automatic report_test(input int t);
    $display("test %0d: %0d checks, %0d errors", t, test_checks[t], test_errors[t]);
    test_done[t] = 1'b1;
  endtask

  task automatic take_retire;
    int          t;
    logic [31:0] rd;
    logic [31:0] data;
    if (exp_rd.size() == 0) begin
      errors++;
      test_errors[6]++;
      $display("unexpected register write to x%0d with %h at %0t", retire_rd, retire_data, $time);
      return;
    end
    t = exp_test.pop_front();
    rd = exp_rd.pop_front();
    data = exp_data.pop_front();
    check_value("retire_rd", {{(32-reg_addr_width){1'b0}}, retire_rd}, rd, t);
    check_value("retire_data", retire_data, data, t);
    // Last entry of this test
    if (exp_test.size() == 0 || exp_test[0] != t) begin
      report_test(t);
    end
  endtask

  task automatic watch_retires;
    int idle;
    int total;
    idle = 0;
    total = 0;
    while (!halted && idle < 200 && total < 2000) begin
      @(negedge clock);
      total++;
      idle++;
      if (retire_valid) begin
        idle = 0;
        take_retire();
      end
    end
    test_checks[6]++;
    if (!halted) begin
      errors++;
      test_errors[6]++;
      if (total >= 2000) begin
        $display("the core did not halt within 2000 cycles");
      end else begin
        $display("no register write seen within 200 cycles");
      end
    end
  endtask

  // Nothing may retire once halted
  task automatic check_tail;
    int n;
    n = 0;
    test_checks[6]++;
    if (exp_rd.size() != 0) begin
      errors++;
      test_errors[6]++;
      $display("%0d expected register writes never appeared", exp_rd.size());
    end
    test_checks[6]++;
    while (n < 10) begin
      @(negedge clock);
      n++;
      if (retire_valid) begin
        errors++;
        test_errors[6]++;
        $display("register write to x%0d with %h after halt at %0t",
                 retire_rd, retire_data, $time);
      end
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    run = 1'b0;
    load_strobe = 1'b0;
    load_addr = '0;
    load_data = '0;
    checks = 0;
    errors = 0;
    for (int t = 1; t <= 6; t++) begin
      test_checks[t] = 0;
      test_errors[t] = 0;
      test_done[t] = 1'b0;
    end
    read_stim();
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    load_program();
    @(negedge clock);
    run = 1'b1;
    watch_retires();
    if (halted) begin
      check_tail();
    end
    for (int t = 1; t <= 6; t++) begin
      if (!test_done[t]) begin
        report_test(t);
      end
    end
    $display("total checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/core_stim.txt
# P word_address instruction (hex)
# E test rd value (test and rd decimal, value hex), in retire order
P 00 00500093
P 01 ffd00113
P 02 002081b3
P 03 40100233
P 04 001122b3
P 05 00f0c313
P 06 0300e393
P 07 0ff17413
P 08 0020f4b3
P 09 0020e533
P 0a 0020c5b3
P 0b 00700613
P 0c 00c606b3
P 0d 40c68733
P 0e 00d707b3
P 0f 20000813
P 10 00f82223
P 11 00482883
P 12 00188913
P 13 00e60663
P 14 06300993
P 15 06300a13
P 16 00d61663
P 17 06200993
P 18 06200a13
P 19 00d60463
P 1a 02100a93
P 1b 12345b37
P 1c 00108013
P 1d fffffbb7
P 1e 00000073
P 1f 00100c13
P 20 00200c93
E 1 1 00000005
E 1 2 fffffffd
E 1 3 00000002
E 1 4 fffffffb
E 1 5 00000001
E 1 6 0000000a
E 1 7 00000035
E 1 8 000000fd
E 1 9 00000005
E 1 10 fffffffd
E 1 11 fffffff8
E 2 12 00000007
E 2 13 0000000e
E 2 14 00000007
E 2 15 00000015
E 3 16 00000200
E 3 17 00000015
E 3 18 00000016
E 4 21 00000021
E 5 22 12345000
E 5 23 fffff000

// File: core_top.f
source/core_pkg.sv
source/instruction_decoder.sv
source/pipeline_datapath.sv
source/hazard_forwarding_unit.sv
source/register_file.sv
source/memory_arbiter.sv
source/unified_memory.sv
source/core_top.sv
verification/core_top_props.sv
verification/core_top_tb.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module core_top_tb -f core_top.f

sim:
	verilator --binary --timing --assert --top-module core_top_tb -f core_top.f -o core_top_sim
	./obj_dir/core_top_sim | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
